// ==== compile.f ====
+incdir+tb
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/access_aligner.sv
verilog/load_extender.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_subsystem \
    -f compile.f -o tb_mem_subsystem > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_mem_subsystem > sim.log 2>&1 \
    || { echo "Simulation did not complete, see sim.log"; exit 1; }

grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== tb/tb_mem_tasks.svh ====
////////////////////////////////////////
// Check and drive
////////////////////////////////////////
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

// One access, checked one cycle later
task automatic drive_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic rd_en, input logic wr_en, input bhw_t code,
                            input logic [4:0] rd_num, input logic reg_wr);
    logic [31:0] exp_data;
    logic        bad;
    logic        load;
    @(negedge i_clk);
    i_mem_addr  = addr;
    i_mem_data  = data;
    i_mem_read  = rd_en;
    i_mem_write = wr_en;
    i_bhw       = code;
    i_rd        = rd_num;
    i_reg_write = reg_wr;
    bad      = access_bad(addr, code);
    load     = rd_en & ~wr_en;           // Store wins
    exp_data = load ? expected_load(addr, code) : addr;
    if (wr_en && !bad) begin
        store_ref(addr, data, code);
    end
    @(posedge i_clk);
    #1;                                  // Past the register update
    check_value("o_wb_data", exp_data, o_wb_data);
    check_value("o_wb_rd", 32'(rd_num), 32'(o_wb_rd));
    check_value("o_wb_reg_write", 32'(reg_wr), 32'(o_wb_reg_write));
    check_value("o_load_valid", 32'(load), 32'(o_load_valid));
    check_value("o_misalign", 32'((rd_en | wr_en) & bad), 32'(o_misalign));
endtask

task automatic check_reset_state();
    check_value("o_wb_data", 32'h0, o_wb_data);
    check_value("o_wb_rd", 32'h0, 32'(o_wb_rd));
    check_value("o_wb_reg_write", 32'h0, 32'(o_wb_reg_write));
    check_value("o_load_valid", 32'h0, 32'(o_load_valid));
    check_value("o_misalign", 32'h0, 32'(o_misalign));
endtask

// Every word gets a known value
task automatic fill_memory();
    for (int w = 0; w < 128; w++) begin
        drive_access(32'(w * 4), fill_word(9'(w * 4)), 1'b0, 1'b1, BHW_W, 5'd0, 1'b0);
    end
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////
task automatic test_word_roundtrip();
    logic [31:0] vals [4] = '{32'hDEADBEEF, 32'h00000001, 32'h80000000, 32'h7FFF0123};
    for (int i = 0; i < 4; i++) begin
        drive_access(32'h40 + 32'(4 * i), vals[i], 1'b0, 1'b1, BHW_W, 5'd0, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
        drive_access(32'h40 + 32'(4 * i), 32'h0, 1'b1, 1'b0, BHW_W, 5'(i + 1), 1'b1);
        drive_access(32'h40 + 32'(4 * i), 32'h0, 1'b1, 1'b0, BHW_WU, 5'(i + 17), 1'b1);
    end
endtask

task automatic test_byte_lanes();
    logic [7:0] lane_vals [4] = '{8'h81, 8'h7F, 8'hC0, 8'h05}; // Top bit set and clear
    for (int k = 0; k < 4; k++) begin
        // Junk above the low byte
        drive_access(32'h80 + 32'(k), {24'hA5A5A5, lane_vals[k]}, 1'b0, 1'b1, BHW_B,
                     5'd0, 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
        drive_access(32'h80 + 32'(k), 32'h0, 1'b1, 1'b0, BHW_B, 5'd3, 1'b1);
        drive_access(32'h80 + 32'(k), 32'h0, 1'b1, 1'b0, BHW_BU, 5'd4, 1'b1);
    end
    drive_access(32'h80, 32'h0, 1'b1, 1'b0, BHW_W, 5'd5, 1'b1); // Assembled word
endtask

task automatic test_halfwords();
    drive_access(32'h90, 32'hABCD8001, 1'b0, 1'b1, BHW_H, 5'd0, 1'b0); // Offset 0
    drive_access(32'h96, 32'h12347FFE, 1'b0, 1'b1, BHW_H, 5'd0, 1'b0); // Offset 2
    for (int a = 32'h90; a < 32'h98; a += 2) begin
        drive_access(32'(a), 32'h0, 1'b1, 1'b0, BHW_H, 5'd6, 1'b1);
        drive_access(32'(a), 32'h0, 1'b1, 1'b0, BHW_HU, 5'd7, 1'b1);
    end
    drive_access(32'h90, 32'h0, 1'b1, 1'b0, BHW_W, 5'd8, 1'b1); // Neighbour halves kept
    drive_access(32'h94, 32'h0, 1'b1, 1'b0, BHW_W, 5'd8, 1'b1);
endtask

task automatic test_misalign();
    drive_access(32'hA1, 32'hFFFFFFFF, 1'b0, 1'b1, BHW_H, 5'd0, 1'b0); // Odd halfword
    drive_access(32'hA5, 32'hFFFFFFFF, 1'b0, 1'b1, BHW_W, 5'd0, 1'b0); // Word at offset 1
    drive_access(32'hA8, 32'hFFFFFFFF, 1'b0, 1'b1, 3'b010, 5'd0, 1'b0); // Bad size code
    for (int a = 32'hA0; a < 32'hAC; a += 4) begin
        drive_access(32'(a), 32'h0, 1'b1, 1'b0, BHW_W, 5'd9, 1'b1);     // Still fill data
    end
    drive_access(32'hA2, 32'h0, 1'b1, 1'b0, BHW_W, 5'd10, 1'b1);
    drive_access(32'hA3, 32'h0, 1'b1, 1'b0, BHW_HU, 5'd11, 1'b1);
    drive_access(32'hA0, 32'h0, 1'b1, 1'b0, 3'b010, 5'd12, 1'b1);
endtask

task automatic test_passthrough();
    drive_access(32'h12345678, 32'h0, 1'b0, 1'b0, BHW_W, 5'd13, 1'b1); // ALU result
    drive_access(32'hFFFF0003, 32'h0, 1'b0, 1'b0, BHW_W, 5'd14, 1'b1); // No flag idle
    drive_access(32'h000000B0, 32'h0BADF00D, 1'b1, 1'b1, BHW_W, 5'd15, 1'b1);
    drive_access(32'h000000B0, 32'h0, 1'b1, 1'b0, BHW_W, 5'd16, 1'b1); // Store landed
endtask

task automatic test_random_traffic(input int n_ops);
    bhw_t        codes [6] = '{BHW_B, BHW_H, BHW_W, BHW_BU, BHW_HU, BHW_WU};
    bhw_t        code;
    logic [31:0] rnd;
    logic [31:0] data;
    logic [31:0] addr;
    int          pick;
    for (int n = 0; n < n_ops; n++) begin
        rnd  = $random(seed);
        data = $random(seed);
        pick = int'(rnd[15:8]) % 6;
        code = codes[pick];
        addr = {23'b0, rnd[24:16]};
        if (byte_count(code) == 2) addr[0] = 1'b0;   // Keep aligned
        if (byte_count(code) == 4) addr[1:0] = 2'b00;
        drive_access(addr, data, ~rnd[0], rnd[0], code, rnd[6:2], rnd[1]);
    end
endtask

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
    import mem_pkg::*;

    ////////////////////////////////////////
    // Run length
    ////////////////////////////////////////
    localparam int N_RANDOM   = 1200;                // Random accesses
    localparam int EST_CYCLES = 10 + 128 + 300 + N_RANDOM; // Reset, fill, directed, random
    localparam int MAX_CYCLES = 5000;                // About three times the estimate

    // DUT inputs
    logic                i_clk;
    logic                i_rst_n;
    logic [NB_WIDTH-1:0] i_mem_addr;
    logic [NB_WIDTH-1:0] i_mem_data;
    logic                i_mem_read;
    logic                i_mem_write;
    bhw_t                i_bhw;
    logic [NB_REG-1:0]   i_rd;
    logic                i_reg_write;

    // DUT outputs
    logic [NB_WIDTH-1:0] o_wb_data;
    logic [NB_REG-1:0]   o_wb_rd;
    logic                o_wb_reg_write;
    logic                o_load_valid;
    logic                o_misalign;

    logic [7:0] ref_mem [512]; // Byte model of the data RAM
    int         err_count   = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    int         seed;

    mem_subsystem_top mem_subsystem_top_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mem_addr     (i_mem_addr),
        .i_mem_data     (i_mem_data),
        .i_mem_read     (i_mem_read),
        .i_mem_write    (i_mem_write),
        .i_bhw          (i_bhw),
        .i_rd           (i_rd),
        .i_reg_write    (i_reg_write),
        .o_wb_data      (o_wb_data),
        .o_wb_rd        (o_wb_rd),
        .o_wb_reg_write (o_wb_reg_write),
        .o_load_valid   (o_load_valid),
        .o_misalign     (o_misalign)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk; // 10 ns period
    end

    // Run limit
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run passed %0d cycles (estimate %0d)", MAX_CYCLES, EST_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic int byte_count(input bhw_t code);
        case (code[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    // Size 10, odd halfword or unaligned word
    function automatic logic access_bad(input logic [31:0] addr, input bhw_t code);
        case (code[1:0])
            2'b00:   return 1'b0;
            2'b01:   return addr[0];
            2'b11:   return addr[1:0] != 2'b00;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr, input bhw_t code);
        logic [31:0] val;
        logic [8:0]  base;
        int          nbytes;
        if (access_bad(addr, code)) begin
            return 32'h0; // Dropped access
        end
        base   = addr[8:0];
        nbytes = byte_count(code);
        val    = 32'h0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = ref_mem[base + 9'(i)]; // Little endian
        end
        // Sign fill above the top loaded bit
        if (!code[2] && val[8*nbytes-1]) begin
            for (int b = 8*nbytes; b < 32; b++) begin
                val[b] = 1'b1;
            end
        end
        return val;
    endfunction

    function automatic void store_ref(input logic [31:0] addr, input logic [31:0] data,
                                      input bhw_t code);
        logic [8:0] base;
        base = addr[8:0];
        for (int i = 0; i < byte_count(code); i++) begin
            ref_mem[base + 9'(i)] = data[8*i +: 8];
        end
    endfunction

    // Pattern covers all nine address bits
    function automatic logic [31:0] fill_word(input logic [8:0] a);
        return {a ^ 9'h15A, 7'h2B, a, 7'h11};
    endfunction

    `include "tb_mem_tasks.svh"

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        seed        = 63326;
        i_rst_n     = 1'b0;
        i_mem_addr  = '0;
        i_mem_data  = '0;
        i_mem_read  = 1'b0;
        i_mem_write = 1'b0;
        i_bhw       = BHW_W;
        i_rd        = '0;
        i_reg_write = 1'b0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        check_reset_state();

        fill_memory();
        test_word_roundtrip();
        test_byte_lanes();
        test_halfwords();
        test_misalign();
        test_passthrough();
        test_random_traffic(N_RANDOM);

        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/access_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_aligner (
    input  wire logic [1:0]                  i_addr_low,   // Byte offset in word
    input  wire mem_pkg::bhw_t               i_bhw,        // Size code
    input  wire logic [mem_pkg::NB_WIDTH-1:0] i_store_data, // Register value
    output mem_pkg::byte_en_t                o_byte_en,    // Lane mask
    output logic [mem_pkg::NB_WIDTH-1:0]     o_lane_data,  // Data placed in lanes
    output logic                             o_misalign    // Bad offset or bad code
);
    import mem_pkg::*;

    ////////////////////////////////////////
    // Lane decode
    ////////////////////////////////////////
    always_comb begin
        // Defaults give no access
        o_byte_en   = BE_NONE;
        o_lane_data = i_store_data;
        o_misalign  = 1'b0;

        case (i_bhw)
            BHW_B, BHW_BU: begin
                // Any offset is fine for a byte
                o_byte_en   = BE_BYTE0 << i_addr_low;
                o_lane_data = {NB_LANES{i_store_data[NB_BYTE-1:0]}};
            end
            BHW_H, BHW_HU: begin
                // Halfword copied into both halves
                o_lane_data = {(NB_LANES/2){i_store_data[2*NB_BYTE-1:0]}};
                if (i_addr_low[0]) begin
                    o_misalign = 1'b1; // Odd address
                end else begin
                    o_byte_en = i_addr_low[1] ? BE_HI_HALF : BE_LO_HALF;
                end
            end
            BHW_W, BHW_WU: begin
                if (i_addr_low != 2'b00) begin
                    o_misalign = 1'b1; // Word must sit on a word boundary
                end else begin
                    o_byte_en = BE_ALL;
                end
            end
            default: begin
                // Code 10 in the size field
                o_misalign = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input wire logic  i_clk,
    mem_bus_if.slave  bus     // Stage drives address, mask and data
);
    import mem_pkg::*;

    localparam int N_WORDS = 2 ** NB_WORD_ADDR; // 128 words

    // Storage, contents undefined after reset
    logic [NB_WIDTH-1:0] mem [N_WORDS];

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////
    // Zero cycle read, follows the word index
    assign bus.rdata = mem[bus.word_addr];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (bus.we) begin
            for (int k = 0; k < NB_LANES; k++) begin
                if (bus.byte_en[k]) begin
                    // One lane at a time
                    mem[bus.word_addr][k*NB_BYTE +: NB_BYTE] <=
                        bus.wdata[k*NB_BYTE +: NB_BYTE];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_extender.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extender (
    input  wire logic [mem_pkg::NB_WIDTH-1:0] i_rdata,     // Raw RAM word
    input  wire logic [1:0]                  i_addr_low,  // Byte offset in word
    input  wire mem_pkg::bhw_t               i_bhw,       // Size code
    input  wire mem_pkg::byte_en_t           i_byte_en,   // Mask from the aligner
    output logic [mem_pkg::NB_WIDTH-1:0]     o_load_data  // Extended result
);
    import mem_pkg::*;

    logic [NB_WIDTH-1:0]   shifted;   // Addressed lane moved to bit 0
    logic [NB_BYTE-1:0]    sel_byte;
    logic [2*NB_BYTE-1:0]  sel_half;
    logic                  byte_fill; // Extension bit for bytes
    logic                  half_fill; // Extension bit for halfwords

    ////////////////////////////////////////
    // Lane select
    ////////////////////////////////////////
    assign shifted  = i_rdata >> {i_addr_low, 3'b000}; // Offset times 8
    assign sel_byte = shifted[NB_BYTE-1:0];
    assign sel_half = shifted[2*NB_BYTE-1:0];

    // Zero when the unsigned bit is set
    assign byte_fill = ~i_bhw[BHW_UNS_BIT] & sel_byte[NB_BYTE-1];
    assign half_fill = ~i_bhw[BHW_UNS_BIT] & sel_half[2*NB_BYTE-1];

    ////////////////////////////////////////
    // Extension
    ////////////////////////////////////////
    always_comb begin
        o_load_data = '0; // Empty mask reads as zero
        if (i_byte_en != BE_NONE) begin
            case (i_bhw)
                BHW_B, BHW_BU: begin
                    o_load_data = {{(NB_WIDTH-NB_BYTE){byte_fill}}, sel_byte};
                end
                BHW_H, BHW_HU: begin
                    o_load_data = {{(NB_WIDTH-2*NB_BYTE){half_fill}}, sel_half};
                end
                BHW_W, BHW_WU: begin
                    o_load_data = i_rdata; // Nothing to extend
                end
                default: begin
                    o_load_data = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////
// Memory stage to data RAM
////////////////////////////////////////
interface mem_bus_if;
    import mem_pkg::*;

    logic                    we;        // Write strobe
    byte_en_t                byte_en;   // Active lanes
    logic [NB_WORD_ADDR-1:0] word_addr; // Word index
    logic [NB_WIDTH-1:0]     wdata;     // Lane aligned store data
    logic [NB_WIDTH-1:0]     rdata;     // Combinational read word

    // Stage side
    modport master (
        output we,
        output byte_en,
        output word_addr,
        output wdata,
        input  rdata
    );

    // RAM side
    modport slave (
        input  we,
        input  byte_en,
        input  word_addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int NB_WIDTH     = 32;  // Data and address bus
    localparam int NB_ADDR      = 9;   // Byte address into 512 bytes
    localparam int NB_WORD_ADDR = 7;   // Word index into 128 words
    localparam int NB_LANES     = 4;   // Byte lanes per word
    localparam int NB_BYTE      = 8;   // Bits per lane
    localparam int NB_REG       = 5;   // Register file index

    ////////////////////////////////////////
    // Access size codes
    ////////////////////////////////////////
    // Bit 2 selects zero extension, bits 1..0 the size
    typedef logic [2:0] bhw_t;

    localparam bhw_t BHW_B  = 3'b000;  // Signed byte
    localparam bhw_t BHW_H  = 3'b001;  // Signed halfword
    localparam bhw_t BHW_W  = 3'b011;  // Word
    localparam bhw_t BHW_BU = 3'b100;  // Unsigned byte
    localparam bhw_t BHW_HU = 3'b101;  // Unsigned halfword
    localparam bhw_t BHW_WU = 3'b111;  // Same as word at 32 bits

    localparam int BHW_UNS_BIT = 2;    // Zero extension flag

    ////////////////////////////////////////
    // Lane masks
    ////////////////////////////////////////
    // Bit k covers bits 8k+7 down to 8k
    typedef logic [NB_LANES-1:0] byte_en_t;

    localparam byte_en_t BE_NONE    = 4'b0000; // No access
    localparam byte_en_t BE_BYTE0   = 4'b0001; // Shifted by the byte offset
    localparam byte_en_t BE_LO_HALF = 4'b0011; // Lanes 0 and 1
    localparam byte_en_t BE_HI_HALF = 4'b1100; // Lanes 2 and 3
    localparam byte_en_t BE_ALL     = 4'b1111; // Full word

endpackage

`default_nettype wire

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst_n,
    input  wire logic [mem_pkg::NB_WIDTH-1:0] i_mem_addr,  // ALU result
    input  wire logic [mem_pkg::NB_WIDTH-1:0] i_mem_data,  // Store data
    input  wire logic                        i_mem_read,  // Load strobe
    input  wire logic                        i_mem_write, // Store strobe
    input  wire mem_pkg::bhw_t               i_bhw,       // Size code
    input  wire logic [mem_pkg::NB_REG-1:0]  i_rd,        // Destination register
    input  wire logic                        i_reg_write, // Writeback enable
    mem_bus_if.master                        bus,         // To the data RAM
    output logic [mem_pkg::NB_WIDTH-1:0]     o_wb_data,
    output logic [mem_pkg::NB_REG-1:0]       o_wb_rd,
    output logic                             o_wb_reg_write,
    output logic                             o_load_valid,
    output logic                             o_misalign
);
    import mem_pkg::*;

    byte_en_t            byte_en;    // Lane mask from the aligner
    logic [NB_WIDTH-1:0] lane_data;  // Store data in lanes
    logic                align_err;  // Bad offset or bad code
    logic [NB_WIDTH-1:0] load_data;  // Extended load word
    logic                access_req; // Any memory request
    logic                load_req;   // Load without a store

    ////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////
    assign access_req = i_mem_read | i_mem_write;
    assign load_req   = i_mem_read & ~i_mem_write; // Store wins when both set

    ////////////////////////////////////////
    // Alignment and extension
    ////////////////////////////////////////
    access_aligner access_aligner_i (
        .i_addr_low   (i_mem_addr[1:0]),
        .i_bhw        (i_bhw),
        .i_store_data (i_mem_data),
        .o_byte_en    (byte_en),
        .o_lane_data  (lane_data),
        .o_misalign   (align_err)
    );

    load_extender load_extender_i (
        .i_rdata     (bus.rdata),
        .i_addr_low  (i_mem_addr[1:0]),
        .i_bhw       (i_bhw),
        .i_byte_en   (byte_en),
        .o_load_data (load_data)
    );

    ////////////////////////////////////////
    // Memory bus
    ////////////////////////////////////////
    assign bus.word_addr = i_mem_addr[NB_ADDR-1:2];           // Drop byte offset
    assign bus.byte_en   = byte_en;                           // Out on loads too
    assign bus.wdata     = lane_data;
    assign bus.we        = i_mem_write & (byte_en != BE_NONE); // No write when misaligned

    ////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_data      <= '0;
            o_wb_rd        <= '0;
            o_wb_reg_write <= 1'b0;
            o_load_valid   <= 1'b0;
            o_misalign     <= 1'b0;
        end else begin
            // Load result on a load, address otherwise
            o_wb_data      <= load_req ? load_data : i_mem_addr;
            o_wb_rd        <= i_rd;
            o_wb_reg_write <= i_reg_write;
            o_load_valid   <= load_req;               // One cycle pulse
            o_misalign     <= access_req & align_err; // Only on real accesses
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst_n,
    input  wire logic [mem_pkg::NB_WIDTH-1:0] i_mem_addr,     // ALU result
    input  wire logic [mem_pkg::NB_WIDTH-1:0] i_mem_data,     // Store data
    input  wire logic                        i_mem_read,
    input  wire logic                        i_mem_write,
    input  wire mem_pkg::bhw_t               i_bhw,          // Size code
    input  wire logic [mem_pkg::NB_REG-1:0]  i_rd,
    input  wire logic                        i_reg_write,
    output logic [mem_pkg::NB_WIDTH-1:0]     o_wb_data,      // Writeback word
    output logic [mem_pkg::NB_REG-1:0]       o_wb_rd,
    output logic                             o_wb_reg_write,
    output logic                             o_load_valid,   // Load completed
    output logic                             o_misalign      // Access dropped
);

    ////////////////////////////////////////
    // Stage to RAM bus
    ////////////////////////////////////////
    mem_bus_if mem_bus ();

    mem_stage mem_stage_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mem_addr     (i_mem_addr),
        .i_mem_data     (i_mem_data),
        .i_mem_read     (i_mem_read),
        .i_mem_write    (i_mem_write),
        .i_bhw          (i_bhw),
        .i_rd           (i_rd),
        .i_reg_write    (i_reg_write),
        .bus            (mem_bus.master),
        .o_wb_data      (o_wb_data),
        .o_wb_rd        (o_wb_rd),
        .o_wb_reg_write (o_wb_reg_write),
        .o_load_valid   (o_load_valid),
        .o_misalign     (o_misalign)
    );

    // 512 byte data memory
    data_ram data_ram_i (
        .i_clk (i_clk),
        .bus   (mem_bus.slave)
    );

endmodule

`default_nettype wire
